// File: build.f
+incdir+design
design/console_bus_pkg.sv
design/addr_decode.sv
design/scratchpad_ram.sv
design/byte_mux.sv
design/grom_port.sv
design/console_bus.sv
sim/clk_gen.sv
sim/console_bus_asserts.sv
sim/console_bus_tb.sv

// File: Bender.yml
package:
  name: console_bus

sources:
  - include_dirs:
      - design
    files:
      - design/console_bus_pkg.sv
      - design/addr_decode.sv
      - design/scratchpad_ram.sv
      - design/byte_mux.sv
      - design/grom_port.sv
      - design/console_bus.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/clk_gen.sv
      - sim/console_bus_asserts.sv
      - sim/console_bus_tb.sv

// File: sim/console_bus_tb.sv
`include "console_bus_cfg.svh"

module console_bus_tb
   import console_bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          CLK_PERIOD = 100;
   localparam int          BURST      = 16;
   localparam int          GROM_CYC   = 1 + 2 * (1 + `GROM_WAIT);   // drive to ready high
   localparam int          TEST_CYC   = 10 + 3 * (2 * BURST + 4) + 5 * 2 +
                                        (GROM_CYC + 2) * (2 * BURST + 8);
   localparam int          WATCHDOG   = 8 * TEST_CYC;
   localparam logic [15:0] GRD_DATA   = `GROM_BASE;
   localparam logic [15:0] GRD_ADDR   = `GROM_BASE | (16'd1 << `GROM_MO_BIT);
   localparam logic [15:0] GWR_DATA   = `GROM_BASE | (16'd1 << `GROM_WR_BIT);
   localparam logic [15:0] GWR_ADDR   = GWR_DATA | (16'd1 << `GROM_MO_BIT);

   logic       clk;
   logic       arst_n;
   logic       memen;
   logic       we;
   logic       dbin;
   word_addr_t a;
   word_t      q;
   word_t      d;
   logic       ready;
   grom_addr_t grom_addr;

   word_t      sp_mem [`SCRATCH_WORDS];   // reference model
   byte_t      grom_mem [`GROM_BYTES];
   grom_addr_t grom_cnt;
   int         errors;
   int         tests_ok;
   int         tests_bad;
   int         cycles;                    // length of the last bus cycle

   clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clk (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   console_bus dut0 (
      .clk               (clk),
      .arst_n_i          (arst_n),
      .memen_i           (memen),
      .we_i              (we),
      .dbin_i            (dbin),
      .a_i               (a),
      .q_i               (q),
      .d_o               (d),
      .ready_o           (ready),
      .debug_grom_addr_o (grom_addr)
   );

   bind console_bus console_bus_asserts u_asserts (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .memen_i       (memen_i),
      .dbin_i        (dbin_i),
      .a_i           (a_i),
      .ready_i       (ready_o),
      .d_i           (d_o),
      .gready_i      (gready),
      .grom_strobe_i (grom_strobe),
      .grom_addr_i   (debug_grom_addr_o)
   );

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got) begin
         $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic bus_cycle(input logic [15:0] byte_addr, input logic write,
                            input word_t wdata, output word_t rdata);
      int n;
      a     = byte_addr[15:1];
      q     = wdata;
      we    = write;
      dbin  = !write;
      memen = 1'b1;
      n     = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!ready && n < GROM_CYC + 8);
      if (!ready) begin
         $display("bus cycle to %h got no ready within %0d cycles", byte_addr, n);
         errors++;
      end
      rdata  = d;
      cycles = n;
      @(negedge clk);       // cpu took the data on the rise before
      memen = 1'b0;
      we    = 1'b0;
      dbin  = 1'b0;
      @(negedge clk);
   endtask

   task automatic end_test(input string name);
      if (errors == 0) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", name, errors);
      end
      errors = 0;
   endtask

   task automatic grom_load(input word_t v);
      word_t rd;
      bus_cycle(GWR_ADDR, 1'b1, v, rd);
      grom_cnt = {grom_cnt[7:0], v[15:8]};   // high byte goes out first
      grom_cnt = {grom_cnt[7:0], v[7:0]};
      check("debug_grom_addr_o", grom_cnt, grom_addr);
   endtask

   task automatic grom_write(input word_t w);
      word_t rd;
      bus_cycle(GWR_DATA, 1'b1, w, rd);
      grom_mem[grom_cnt % `GROM_BYTES] = w[15:8];
      grom_cnt = grom_cnt + 1'b1;
      grom_mem[grom_cnt % `GROM_BYTES] = w[7:0];
      grom_cnt = grom_cnt + 1'b1;
      check("debug_grom_addr_o", grom_cnt, grom_addr);
   endtask

   task automatic grom_read();
      word_t got;
      word_t exp;
      exp[15:8] = grom_mem[grom_cnt % `GROM_BYTES];
      grom_cnt  = grom_cnt + 1'b1;
      exp[7:0]  = grom_mem[grom_cnt % `GROM_BYTES];
      grom_cnt  = grom_cnt + 1'b1;
      bus_cycle(GRD_DATA, 1'b0, '0, got);
      check("d_o", exp, got);
      check("debug_grom_addr_o", grom_cnt, grom_addr);
   endtask

   initial begin
      word_t       w;
      word_t       got;
      logic [15:0] sp_addr [BURST];
      int          k;
      memen     = 1'b0;
      we        = 1'b0;
      dbin      = 1'b0;
      a         = '0;
      q         = '0;
      grom_cnt  = '0;
      errors    = 0;
      tests_ok  = 0;
      tests_bad = 0;
      cycles    = 0;
      void'($urandom(67));
      @(posedge arst_n);
      @(negedge clk);

      check("ready_o", 1, ready);
      check("debug_grom_addr_o", 0, grom_addr);
      check("d_o", 16'hffff, d);
      end_test("reset");

      for (int i = 0; i < BURST; i++) begin
         sp_addr[i] = `SCRATCH_BASE + 16'(2 * ($urandom % 512));
         w = 16'($urandom);
         bus_cycle(sp_addr[i], 1'b1, w, got);
         sp_mem[(sp_addr[i] >> 1) % `SCRATCH_WORDS] = w;
      end
      for (int i = 0; i < BURST; i++) begin
         bus_cycle(sp_addr[i], 1'b0, '0, got);
         check("d_o", sp_mem[(sp_addr[i] >> 1) % `SCRATCH_WORDS], got);
         check("ready_o cycles", 1, cycles);
      end
      k = $urandom % 128;   // word inside the 256 byte image
      w = 16'($urandom);
      bus_cycle(`SCRATCH_BASE + 16'(2 * k), 1'b1, w, got);
      for (int m = 1; m < 4; m++) begin
         bus_cycle(`SCRATCH_BASE + 16'(256 * m + 2 * k), 1'b0, '0, got);
         check("d_o", w, got);
      end
      end_test("scratchpad");

      bus_cycle(16'h4000, 1'b0, '0, got);
      check("d_o", 16'hffff, got);
      check("ready_o cycles", 1 + 2, cycles);
      bus_cycle(16'ha000, 1'b0, '0, got);
      check("d_o", 16'hffff, got);
      end_test("unmapped");

      grom_load(16'($urandom));
      bus_cycle(GRD_ADDR, 1'b0, '0, got);
      check("d_o", grom_cnt, got);
      check("debug_grom_addr_o", grom_cnt, grom_addr);
      end_test("grom address");

      w = 16'($urandom);
      grom_load(w);
      for (int i = 0; i < BURST; i++) begin
         grom_write(16'($urandom));
      end
      grom_load(w);
      for (int i = 0; i < BURST; i++) begin
         grom_read();
      end
      end_test("grom data");

      grom_write(16'($urandom));
      check("ready_o cycles", GROM_CYC, cycles);
      grom_load(grom_cnt - 16'd2);
      grom_read();
      check("ready_o cycles", GROM_CYC, cycles);
      end_test("grom stall");

      $display("tests passed %0d failed %0d, assertion failures %0d",
               tests_ok, tests_bad, dut0.u_asserts.fail_cnt);
      if (tests_bad == 0 && dut0.u_asserts.fail_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG * CLK_PERIOD);
      $display("run timed out after %0d cycles", WATCHDOG);
      $display("sim failed");
      $finish;
   end

endmodule

// File: sim/console_bus_asserts.sv
`include "console_bus_cfg.svh"

module console_bus_asserts
   import console_bus_pkg::*;
(
   input logic       clk,
   input logic       arst_n_i,
   input logic       memen_i,
   input logic       dbin_i,
   input word_addr_t a_i,
   input logic       ready_i,
   input word_t      d_i,
   input logic       gready_i,
   input logic       grom_strobe_i,
   input grom_addr_t grom_addr_i
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [15:0] byte_addr;
   logic        in_scratch;
   logic        in_grom;
   int unsigned fail_cnt = 0;

   // own decode of the memory map
   assign byte_addr  = {a_i, 1'b0};
   assign in_scratch = (byte_addr >= `SCRATCH_BASE) && (byte_addr <= `SCRATCH_LAST);
   assign in_grom    = (byte_addr >= `GROM_BASE) && (byte_addr <= `GROM_LAST);

   ready_after_reset: assert property (@(posedge clk) $rose(arst_n_i) |-> ready_i)
   else begin
      fail_cnt++;
      $error("ready low in the first cycle after reset");
   end

   scratch_ready_high: assert property (@(posedge clk) disable iff (!arst_n_i)
      memen_i && in_scratch |-> ready_i)
   else begin
      fail_cnt++;
      $error("ready fell during a scratchpad cycle");
   end

   unmapped_reads_ff: assert property (@(posedge clk) disable iff (!arst_n_i)
      memen_i && dbin_i && !in_scratch && !in_grom && ready_i |-> d_i == 16'hffff)
   else begin
      fail_cnt++;
      $error("unmapped read returned %h", d_i);
   end

   grom_addr_on_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
      !grom_strobe_i |=> $stable(grom_addr_i))
   else begin
      fail_cnt++;
      $error("grom counter moved without a strobe");
   end

   stall_holds_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
      !gready_i |-> !ready_i)
   else begin
      fail_cnt++;
      $error("ready high while the grom is busy");
   end

endmodule

// File: sim/clk_gen.sv
module clk_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 5
) (
   output logic clk_o,
   output logic arst_n_o
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;      // released on a falling edge
   end

endmodule

// File: design/console_bus.sv
`include "console_bus_cfg.svh"

module console_bus
   import console_bus_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       memen_i,
   input  logic       we_i,
   input  logic       dbin_i,
   input  word_addr_t a_i,
   input  word_t      q_i,
   output word_t      d_o,
   output logic       ready_o,
   output grom_addr_t debug_grom_addr_o
);

   logic  scratch_sel;
   logic  grom_sel;
   logic  grom_wr_half;
   logic  mux_start;
   logic  sysrdy;
   logic  b_strobe;
   logic  b_we;
   logic  grom_strobe;
   logic  gready;
   byte_t q8;
   byte_t d8;
   byte_t d8_grom;
   word_t d_sp;
   word_t d_mpx;
   logic  sp_valid;
   logic  mpx_valid;
   logic  grom_valid;

   assign grom_wr_half = a_i[`GROM_WR_BIT-1];

   // everything outside the scratchpad goes through the 8 bit side
   assign mux_start = memen_i && !scratch_sel;

   // direction must match the half of the window
   assign grom_strobe = b_strobe && grom_sel && (b_we == grom_wr_half);

   assign sysrdy = grom_sel ? gready : 1'b1;

   // wired AND, an undriven byte reads ff
   assign d8  = 8'hff & (grom_valid ? d8_grom : 8'hff);
   assign d_o = 16'hffff &
                (sp_valid  ? d_sp  : 16'hffff) &
                (mpx_valid ? d_mpx : 16'hffff);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sp_valid   <= 1'b0;
         mpx_valid  <= 1'b0;
         grom_valid <= 1'b0;
      end else begin
         sp_valid   <= dbin_i && scratch_sel;
         mpx_valid  <= dbin_i && !scratch_sel;
         grom_valid <= dbin_i && grom_sel && !grom_wr_half;
      end
   end

   addr_decode u_decode (
      .a_i           (a_i),
      .memen_i       (memen_i),
      .scratch_sel_o (scratch_sel),
      .grom_sel_o    (grom_sel)
   );

   scratchpad_ram u_scratch (
      .clk  (clk),
      .cs_i (scratch_sel),
      .we_i (we_i),
      .a_i  (a_i),
      .d_i  (q_i),
      .q_o  (d_sp)
   );

   byte_mux u_mux (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .start_i    (mux_start),
      .we_i       (we_i),
      .sysrdy_i   (sysrdy),
      .q_i        (q_i),
      .d8_i       (d8),
      .ready_o    (ready_o),
      .b_strobe_o (b_strobe),
      .b_we_o     (b_we),
      .b_a0_o     (),            // no byte addressed device on the 8 bit side yet
      .q8_o       (q8),
      .d_o        (d_mpx)
   );

   grom_port u_grom (
      .clk               (clk),
      .arst_n_i          (arst_n_i),
      .strobe_i          (grom_strobe),
      .we_i              (b_we),
      .addr_port_i       (a_i[`GROM_MO_BIT-1]),
      .d_i               (q8),
      .q_o               (d8_grom),
      .gready_o          (gready),
      .debug_grom_addr_o (debug_grom_addr_o)
   );

endmodule

// File: design/grom_port.sv
`include "console_bus_cfg.svh"

module grom_port
   import console_bus_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       strobe_i,
   input  logic       we_i,
   input  logic       addr_port_i,
   input  byte_t      d_i,
   output byte_t      q_o,
   output logic       gready_o,
   output grom_addr_t debug_grom_addr_o
);

   localparam int IDX_W  = $clog2(`GROM_BYTES);
   localparam int WAIT_W = ($clog2(`GROM_WAIT) > 0) ? $clog2(`GROM_WAIT) : 1;

   byte_t             mem [`GROM_BYTES];
   grom_addr_t        addr_q;
   logic              lo_next_q;    // address read hands out low byte next
   logic [WAIT_W-1:0] wait_q;
   logic [IDX_W-1:0]  idx;
   logic              data_rd;
   logic              data_wr;
   logic              addr_rd;
   logic              addr_wr;

   assign idx     = addr_q[IDX_W-1:0];
   assign data_rd = strobe_i && !addr_port_i && !we_i;
   assign data_wr = strobe_i && !addr_port_i && we_i;
   assign addr_rd = strobe_i && addr_port_i && !we_i;
   assign addr_wr = strobe_i && addr_port_i && we_i;

   // low in the strobe cycle and GROM_WAIT-1 more
   assign gready_o = !strobe_i && (wait_q == '0);

   assign debug_grom_addr_o = addr_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wait_q    <= '0;
         addr_q    <= '0;
         lo_next_q <= 1'b0;
      end else begin
         if (strobe_i) begin
            wait_q <= WAIT_W'(`GROM_WAIT - 1);
         end else if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end

         if (data_rd || data_wr) begin
            addr_q    <= addr_q + 16'd1;
            lo_next_q <= 1'b0;
         end

         if (addr_wr) begin
            addr_q    <= {addr_q[7:0], d_i};   // two writes load hi then lo
            lo_next_q <= !lo_next_q;
         end

         if (addr_rd) begin
            lo_next_q <= !lo_next_q;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (data_wr) begin
         mem[idx] <= d_i;
      end
      if (data_rd) begin
         q_o <= mem[idx];
      end else if (addr_rd) begin
         q_o <= lo_next_q ? addr_q[7:0] : addr_q[15:8];
      end
   end

endmodule

// File: design/byte_mux.sv
module byte_mux
   import console_bus_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n_i,
   input  logic  start_i,
   input  logic  we_i,
   input  logic  sysrdy_i,
   input  word_t q_i,
   input  byte_t d8_i,
   output logic  ready_o,
   output logic  b_strobe_o,
   output logic  b_we_o,
   output logic  b_a0_o,
   output byte_t q8_o,
   output word_t d_o
);

   mux_state_t state_q;
   logic       issued_q;     // strobe already sent in this phase
   logic       we_q;
   logic       in_phase;
   byte_t      hi_q;
   byte_t      lo_q;

   assign in_phase = (state_q == MUX_HI) || (state_q == MUX_LO);

   // ready drops the cycle after start is taken
   assign ready_o = (state_q == MUX_IDLE) || (state_q == MUX_DONE);

   assign b_strobe_o = in_phase && !issued_q;
   assign b_we_o     = we_q;
   assign b_a0_o     = (state_q == MUX_LO);
   assign q8_o       = b_a0_o ? q_i[7:0] : q_i[15:8];
   assign d_o        = {hi_q, lo_q};

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= MUX_IDLE;
         issued_q <= 1'b0;
         we_q     <= 1'b0;
      end else begin
         case (state_q)
            MUX_IDLE: begin
               issued_q <= 1'b0;
               if (start_i) begin
                  state_q <= MUX_HI;
                  we_q    <= we_i;
               end
            end
            MUX_HI: begin
               if (sysrdy_i) begin
                  state_q  <= MUX_LO;
                  issued_q <= 1'b0;
               end else begin
                  issued_q <= 1'b1;   // stalled by the device
               end
            end
            MUX_LO: begin
               if (sysrdy_i) begin
                  state_q  <= MUX_DONE;
                  issued_q <= 1'b0;
               end else begin
                  issued_q <= 1'b1;
               end
            end
            MUX_DONE: begin
               state_q <= MUX_IDLE;   // start is not looked at here
            end
            default: begin
               state_q <= MUX_IDLE;
            end
         endcase
      end
   end

   // byte capture at the end of each phase
   always_ff @(posedge clk) begin
      if ((state_q == MUX_HI) && sysrdy_i) begin
         hi_q <= d8_i;
      end
      if ((state_q == MUX_LO) && sysrdy_i) begin
         lo_q <= d8_i;
      end
   end

endmodule

// File: design/scratchpad_ram.sv
`include "console_bus_cfg.svh"

module scratchpad_ram
   import console_bus_pkg::*;
(
   input  logic       clk,
   input  logic       cs_i,
   input  logic       we_i,
   input  word_addr_t a_i,
   input  word_t      d_i,
   output word_t      q_o
);

   localparam int IDX_W = $clog2(`SCRATCH_WORDS);

   word_t            mem [`SCRATCH_WORDS];
   logic [IDX_W-1:0] idx;

   // upper bits dropped, gives the mirrors
   assign idx = a_i[IDX_W-1:0];

   always_ff @(posedge clk) begin
      if (cs_i && we_i) begin
         mem[idx] <= d_i;
      end
      if (cs_i) begin
         q_o <= mem[idx];            // one cycle read latency
      end
   end

endmodule

// File: design/addr_decode.sv
`include "console_bus_cfg.svh"

module addr_decode
   import console_bus_pkg::*;
(
   input  word_addr_t a_i,
   input  logic       memen_i,
   output logic       scratch_sel_o,
   output logic       grom_sel_o
);

   logic [15:0] byte_addr;
   logic        in_scratch;
   logic        in_grom;

   // the cpu never puts out byte bit 0
   assign byte_addr = {a_i, 1'b0};

   // scratchpad mirrors are folded by the ram index
   assign in_scratch = (byte_addr >= `SCRATCH_BASE) &&
                       (byte_addr <= `SCRATCH_LAST);

   // read and write halves, both ports
   assign in_grom = (byte_addr >= `GROM_BASE) &&
                    (byte_addr <= `GROM_LAST);

   assign scratch_sel_o = memen_i && in_scratch;
   assign grom_sel_o    = memen_i && in_grom;

endmodule

// File: design/console_bus_pkg.sv
package console_bus_pkg;

   // cpu side data word
   typedef logic [15:0] word_t;

   // one byte on the multiplexed side
   typedef logic [7:0] byte_t;

   // cpu word address, byte bit 0 comes from the mux
   typedef logic [14:0] word_addr_t;

   // grom auto increment address
   typedef logic [15:0] grom_addr_t;

   // 16 to 8 bit cycle splitter
   typedef enum logic [1:0] {
      MUX_IDLE,
      MUX_HI,      // even byte, b_a0 low
      MUX_LO,      // odd byte
      MUX_DONE     // word assembled, ready high
   } mux_state_t;

endpackage

// File: design/console_bus_cfg.svh
`ifndef CONSOLE_BUS_CFG_SVH
`define CONSOLE_BUS_CFG_SVH

// scratchpad RAM
`define SCRATCH_WORDS 128
`define SCRATCH_BASE  16'h8000     // 256 byte image repeats up to SCRATCH_LAST
`define SCRATCH_LAST  16'h83ff

// GROM store and timing
`define GROM_BYTES    2048         // counter wraps on this size
`define GROM_WAIT     4            // clk cycles of gready low per strobe

// GROM window on the byte address
`define GROM_BASE     16'h9800
`define GROM_LAST     16'h9fff
`define GROM_WR_BIT   10           // set on the write half
`define GROM_MO_BIT   1            // set for the address port

`endif
